// ==== sources.f ====
+incdir+include
src/eth_rx_pkg.sv
src/eth_rx_cfg_regs.sv
src/eth_rx_crc.sv
src/eth_rx_fsm.sv
src/eth_rx_frame_buf.sv
src/eth_rx_top.sv
verification/eth_rx_asserts.sv
verification/eth_rx_tb.sv

// ==== Makefile ====
# Verilator build and run for the Ethernet receive testbench

VERILATOR ?= verilator
TOP       ?= eth_rx_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timescale 1ns/100ps -j 0
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  := NO ERRORS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build $(TOP) with Verilator, run it and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS SIM_ARGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "test passed"; \
	else \
		echo "test failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verification/eth_rx_tb.sv ====
`timescale 1ns/100ps
`include "eth_rx_defs.svh"

module eth_rx_tb
   import eth_rx_pkg::*;
();

   typedef struct packed {
      logic                      cfg_en;
      cfg_op_e                   op;
      logic [31:0]               value;
      logic [47:0]               dest;
      logic [`ETH_RX_ADDR_W-1:0] nbytes;
      logic                      bad_fcs;
      logic                      accept;
      logic                      crc_ok;
   } tcase_t;

   localparam int n_cases = 9;
   localparam logic [`ETH_RX_ADDR_W-1:0] hdr_fcs_last = 17;
   localparam logic [47:0] src_mac = 48'h02_11_22_33_44_55;

   logic                      RX_CLK;
   logic                      rx_rst;
   mii_rx_t                   mii;
   logic                      cfg_stb;
   cfg_wr_t                   cfg;
   logic                      rcv_ack;
   logic [`ETH_RX_ADDR_W-1:0] rd_addr;
   logic [7:0]                rd_data;
   logic                      frame_rdy;
   rx_status_t                status;

   tcase_t     cases [0:n_cases-1];
   logic [7:0] frame [0:`ETH_RX_BUF_DEPTH-1];
   integer     seed;
   int         errors;
   int         timeouts;
   int         checks;

   eth_rx_top i_dut (
      .RX_CLK    (RX_CLK),
      .rx_rst    (rx_rst),
      .mii       (mii),
      .cfg_stb   (cfg_stb),
      .cfg       (cfg),
      .rcv_ack   (rcv_ack),
      .rd_addr   (rd_addr),
      .rd_data   (rd_data),
      .frame_rdy (frame_rdy),
      .status    (status)
   );

   always #20 RX_CLK = ~RX_CLK;

   task automatic check_status(input rx_status_t got, input rx_status_t exp, input int tc);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Fail %0t: case %0d status crc_ok %b last_addr %0d, expected %b %0d",
                  $time, tc, got.crc_ok, got.last_addr, exp.crc_ok, exp.last_addr);
      end
   endtask

   task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input int addr);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Fail %0t: buffer byte %0d is %h, expected %h", $time, addr, got, exp);
      end
   endtask

   task automatic check_flag(input logic got, input logic exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Fail %0t: %s is %b, expected %b", $time, what, got, exp);
      end
   endtask

   task automatic report_timeout(input string what);
      timeouts++;
      $display("timeout at %0t: %s", $time, what);
   endtask

   task automatic wait_frame_rdy(input logic level, input int limit, output logic seen);
      int n;
      n = 0;
      while (frame_rdy !== level && n < limit) begin
         @(posedge RX_CLK);
         n++;
      end
      seen = (frame_rdy === level);
   endtask

   // reflected crc-32 with the FCS sent least significant byte first
   function automatic logic [31:0] eth_fcs(input int len);
      logic [31:0] c;
      int          i;
      int          j;
      c = 32'hFFFFFFFF;
      for (i = 0; i < len; i++) begin
         c = c ^ {24'h0, frame[i]};
         for (j = 0; j < 8; j++) begin
            if (c[0]) begin
               c = (c >> 1) ^ 32'hEDB88320;
            end else begin
               c = c >> 1;
            end
         end
      end
      return ~c;
   endfunction

   task automatic build_frame(input logic [47:0] dest, input int nb, input logic bad_fcs,
                              output int len);
      logic [31:0] r;
      logic [31:0] fcs;
      int          i;
      len = 18 + nb;
      for (i = 0; i < 6; i++) begin
         frame[i]     = dest[47-8*i -: 8];
         frame[6 + i] = src_mac[47-8*i -: 8];
      end
      frame[12] = 8'h88;
      frame[13] = 8'hB5;
      for (i = 0; i < nb; i++) begin
         r = $random(seed);
         frame[14 + i] = r[7:0];
      end
      fcs = eth_fcs(len - 4);
      for (i = 0; i < 4; i++) begin
         frame[len - 4 + i] = fcs[8*i +: 8];
      end
      if (bad_fcs) begin
         frame[len - 1] = frame[len - 1] ^ 8'h08;
      end
   endtask

   // preamble and SFD then each byte low nibble first
   task automatic send_frame(input int len);
      int i;
      for (i = 0; i < 16; i++) begin
         @(posedge RX_CLK);
         mii <= '{dv: 1'b1, nibble: (i == 15) ? 4'hD : 4'h5};
      end
      for (i = 0; i < len; i++) begin
         @(posedge RX_CLK);
         mii <= '{dv: 1'b1, nibble: frame[i][3:0]};
         @(posedge RX_CLK);
         mii <= '{dv: 1'b1, nibble: frame[i][7:4]};
      end
      @(posedge RX_CLK);
      mii <= '{dv: 1'b0, nibble: 4'h0};
   endtask

   task automatic write_cfg(input cfg_op_e op, input logic [31:0] value);
      @(posedge RX_CLK);
      cfg_stb <= 1'b1;
      cfg     <= '{op: op, value: value};
      @(posedge RX_CLK);
      cfg_stb <= 1'b0;
   endtask

   task automatic read_buffer(input int len);
      int a;
      for (a = 0; a < len; a++) begin
         @(posedge RX_CLK);
         rd_addr <= a[`ETH_RX_ADDR_W-1:0];
         @(posedge RX_CLK);
         @(posedge RX_CLK);
         check_byte(rd_data, frame[a], a);
      end
   endtask

   // frame_rdy must drop on the edge after the one that sees rcv_ack
   task automatic ack_frame();
      logic seen;
      @(posedge RX_CLK);
      rcv_ack <= 1'b1;
      @(posedge RX_CLK);
      rcv_ack <= 1'b0;
      wait_frame_rdy(1'b0, 1, seen);
      if (!seen) begin
         report_timeout("frame_rdy still high after rcv_ack");
      end
   endtask

   initial begin
      tcase_t     tc;
      rx_status_t exp_st;
      int         k;
      int         len;
      logic       seen;
      RX_CLK   = 1'b0;
      rx_rst   = 1'b1;
      mii      = '{dv: 1'b0, nibble: 4'h0};
      cfg_stb  = 1'b0;
      cfg      = '{op: SET_MAC_HI, value: 32'h0};
      rcv_ack  = 1'b0;
      rd_addr  = '0;
      seed     = 32'hd6d29e7f;
      errors   = 0;
      timeouts = 0;
      checks   = 0;

      // cfg_en op value dest nbytes bad_fcs accept crc_ok
      cases[0] = '{1'b0, SET_MAC_HI, 32'h0, 48'h0200_00A1_B2C3, 11'd46, 1'b0, 1'b1, 1'b1};
      cases[1] = '{1'b0, SET_MAC_HI, 32'h0, 48'h0200_00A1_B2C3, 11'd46, 1'b1, 1'b1, 1'b0};
      cases[2] = '{1'b0, SET_MAC_HI, 32'h0, 48'h0200_00A1_B2C4, 11'd46, 1'b0, 1'b0, 1'b0};
      cases[3] = '{1'b0, SET_MAC_HI, 32'h0, 48'h0200_00A1_B2C3, 11'd46, 1'b0, 1'b1, 1'b1};
      cases[4] = '{1'b1, SET_NBYTES, 32'd60, 48'h0200_00A1_B2C3, 11'd60, 1'b0, 1'b1, 1'b1};
      // old address no longer matches after the low word changes
      cases[5] = '{1'b1, SET_MAC_LO, 32'h1122_3344, 48'h0200_00A1_B2C3, 11'd60, 1'b0, 1'b0,
                   1'b0};
      cases[6] = '{1'b1, SET_MAC_HI, 32'h0000_0A0B, 48'h0A0B_1122_3344, 11'd60, 1'b0, 1'b1,
                   1'b1};
      cases[7] = '{1'b0, SET_MAC_HI, 32'h0, 48'h0A0B_1122_3344, 11'd60, 1'b1, 1'b1, 1'b0};
      cases[8] = '{1'b1, SET_NBYTES, 32'd100, 48'h0A0B_1122_3344, 11'd100, 1'b0, 1'b1, 1'b1};

      repeat (16) @(posedge RX_CLK);
      rx_rst <= 1'b0;
      @(posedge RX_CLK);
      check_flag(frame_rdy, 1'b0, "frame_rdy after reset");

      for (k = 0; k < n_cases; k++) begin
         tc = cases[k];
         if (tc.cfg_en) begin
            write_cfg(tc.op, tc.value);
         end
         build_frame(tc.dest, int'(tc.nbytes), tc.bad_fcs, len);
         send_frame(len);
         if (tc.accept) begin
            wait_frame_rdy(1'b1, 100, seen);
            if (!seen) begin
               report_timeout($sformatf("no frame_rdy for case %0d", k));
            end else begin
               exp_st.crc_ok    = tc.crc_ok;
               exp_st.last_addr = tc.nbytes + hdr_fcs_last;
               check_status(status, exp_st, k);
               read_buffer(len);
               // status held while frame_rdy waits for rcv_ack
               check_status(status, exp_st, k);
               ack_frame();
            end
         end else begin
            wait_frame_rdy(1'b1, 4 * len, seen);
            check_flag(seen, 1'b0, $sformatf("frame_rdy for rejected case %0d", k));
         end
         repeat (4) @(posedge RX_CLK);
      end

      $display("summary: %0d checks, %0d mismatches, %0d timeouts, %0d assertion failures",
               checks, errors, timeouts, i_dut.u_fsm.u_asserts.fail_count);
      if (errors == 0 && timeouts == 0 && i_dut.u_fsm.u_asserts.fail_count == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

// ==== verification/eth_rx_asserts.sv ====
`timescale 1ns/100ps
`include "eth_rx_defs.svh"

module eth_rx_asserts
   import eth_rx_pkg::*;
(
   input logic    RX_CLK,
   input logic    rx_rst,
   input buf_wr_t buf_wr,
   input logic    frame_rdy,
   input logic    rcv_ack,
   input logic    crc_start,
   input rx_cfg_t rx_cfg
);

   localparam logic [`ETH_RX_ADDR_W-1:0] hdr_fcs_last = 17;

   int                        fail_count = 0;
   logic [`ETH_RX_ADDR_W-1:0] addr_limit;

   // crc_start is high through HUNT, so the last load is at the SFD
   always_ff @(posedge RX_CLK) begin
      if (crc_start) begin
         addr_limit <= rx_cfg.nbytes + hdr_fcs_last;
      end
   end

   // one byte every second clock at most
   wr_spacing: assert property (@(posedge RX_CLK) disable iff (rx_rst)
      buf_wr.en |=> !buf_wr.en)
      else begin
         fail_count++;
         $error("buffer write strobe high on two consecutive cycles");
      end

   rdy_held: assert property (@(posedge RX_CLK) disable iff (rx_rst)
      (frame_rdy && !rcv_ack) |=> frame_rdy)
      else begin
         fail_count++;
         $error("frame_rdy dropped without rcv_ack");
      end

   // last byte of a frame sits at 17 + nbytes
   wr_bound: assert property (@(posedge RX_CLK) disable iff (rx_rst)
      buf_wr.en |-> (buf_wr.addr <= addr_limit))
      else begin
         fail_count++;
         $error("buffer write address beyond end of frame");
      end

endmodule

bind eth_rx_fsm eth_rx_asserts u_asserts (
   .RX_CLK    (RX_CLK),
   .rx_rst    (rx_rst),
   .buf_wr    (buf_wr),
   .frame_rdy (frame_rdy),
   .rcv_ack   (rcv_ack),
   .crc_start (crc_start),
   .rx_cfg    (rx_cfg)
);

// ==== src/eth_rx_top.sv ====
`timescale 1ns/100ps
`include "eth_rx_defs.svh"

module eth_rx_top
   import eth_rx_pkg::*;
(
   input  logic                      RX_CLK,
   input  logic                      rx_rst,
   input  mii_rx_t                   mii,
   input  logic                      cfg_stb,
   input  cfg_wr_t                   cfg,
   input  logic                      rcv_ack,
   input  logic [`ETH_RX_ADDR_W-1:0] rd_addr,
   output logic [7:0]                rd_data,
   output logic                      frame_rdy,
   output rx_status_t                status
);

   rx_cfg_t     rx_cfg;
   buf_wr_t     buf_wr;
   logic        crc_start;
   logic [31:0] crc_value;

   eth_rx_cfg_regs u_cfg_regs (
      .RX_CLK  (RX_CLK),
      .rx_rst  (rx_rst),
      .cfg_stb (cfg_stb),
      .cfg     (cfg),
      .rx_cfg  (rx_cfg)
   );

   eth_rx_fsm u_fsm (
      .RX_CLK    (RX_CLK),
      .rx_rst    (rx_rst),
      .mii       (mii),
      .rx_cfg    (rx_cfg),
      .rcv_ack   (rcv_ack),
      .crc_value (crc_value),
      .buf_wr    (buf_wr),
      .crc_start (crc_start),
      .frame_rdy (frame_rdy),
      .status    (status)
   );

   // crc sees exactly the bytes written to the buffer
   eth_rx_crc u_crc (
      .RX_CLK    (RX_CLK),
      .rx_rst    (rx_rst),
      .start     (crc_start),
      .wr        (buf_wr),
      .crc_value (crc_value)
   );

   eth_rx_frame_buf u_frame_buf (
      .RX_CLK  (RX_CLK),
      .wr      (buf_wr),
      .rd_addr (rd_addr),
      .rd_data (rd_data)
   );

endmodule

// ==== src/eth_rx_frame_buf.sv ====
`timescale 1ns/100ps
`include "eth_rx_defs.svh"

module eth_rx_frame_buf
   import eth_rx_pkg::*;
(
   input  logic                      RX_CLK,
   input  buf_wr_t                   wr,
   input  logic [`ETH_RX_ADDR_W-1:0] rd_addr,
   output logic [7:0]                rd_data
);

   logic [7:0] mem [0:`ETH_RX_BUF_DEPTH-1];

   always_ff @(posedge RX_CLK) begin
      if (wr.en) begin
         mem[wr.addr] <= wr.data;
      end
   end

   // host side, data one cycle after address
   always_ff @(posedge RX_CLK) begin
      rd_data <= mem[rd_addr];
   end

endmodule

// ==== src/eth_rx_fsm.sv ====
`timescale 1ns/100ps
`include "eth_rx_defs.svh"

module eth_rx_fsm
   import eth_rx_pkg::*;
(
   input  logic        RX_CLK,
   input  logic        rx_rst,
   input  mii_rx_t     mii,
   input  rx_cfg_t     rx_cfg,
   input  logic        rcv_ack,
   input  logic [31:0] crc_value,
   output buf_wr_t     buf_wr,
   output logic        crc_start,
   output logic        frame_rdy,
   output rx_status_t  status
);

   localparam logic [`ETH_RX_ADDR_W-1:0] dest_last = 5;
   localparam logic [`ETH_RX_ADDR_W-1:0] frame_extra = 17;

   rx_state_e                 state;
   logic                      phase;
   logic [`ETH_RX_ADDR_W-1:0] addr;
   logic [7:0]                rx_byte;
   logic [7:0]                byte_in;
   logic [39:0]               dest_sr;
   logic [47:0]               mac_q;
   logic [`ETH_RX_ADDR_W-1:0] last_q;
   logic                      wr_en;
   logic [`ETH_RX_ADDR_W-1:0] wr_addr;
   logic [7:0]                wr_data;
   logic                      sfd_hit;
   logic                      byte_done;
   logic                      mac_match;
   logic                      status_load;

   // low nibble arrives first
   assign byte_in = {mii.nibble, rx_byte[7:4]};

   assign sfd_hit     = (state == HUNT) && mii.dv && (byte_in == `ETH_RX_SFD);
   assign byte_done   = ((state == DEST) || (state == BODY)) && mii.dv && phase;
   assign mac_match   = ({dest_sr, byte_in} == mac_q);
   // wr_en low means the crc has taken the last byte
   assign status_load = (state == DONE) && !frame_rdy && !wr_en;

   always_ff @(posedge RX_CLK or posedge rx_rst) begin
      if (rx_rst) begin
         state     <= HUNT;
         phase     <= 1'b0;
         addr      <= '0;
         wr_en     <= 1'b0;
         frame_rdy <= 1'b0;
      end else begin
         wr_en <= 1'b0;
         case (state)
            HUNT: begin
               if (sfd_hit) begin
                  state <= DEST;
                  phase <= 1'b0;
                  addr  <= '0;
               end
            end
            DEST, BODY: begin
               if (!mii.dv) begin
                  // carrier gone mid-frame
                  state <= HUNT;
               end else begin
                  phase <= ~phase;
                  if (phase) begin
                     wr_en <= 1'b1;
                     addr  <= addr + 1'b1;
                     if (state == DEST && addr == dest_last) begin
                        state <= mac_match ? BODY : HUNT;
                     end else if (state == BODY && addr == last_q) begin
                        state <= DONE;
                     end
                  end
               end
            end
            DONE: begin
               if (frame_rdy) begin
                  if (rcv_ack) begin
                     frame_rdy <= 1'b0;
                     state     <= HUNT;
                  end
               end else if (status_load) begin
                  frame_rdy <= 1'b1;
               end
            end
            default: begin
               state <= HUNT;
            end
         endcase
      end
   end

   always_ff @(posedge RX_CLK) begin
      if (mii.dv) begin
         rx_byte <= byte_in;
      end
      // config is frozen for the whole frame
      if (sfd_hit) begin
         mac_q  <= rx_cfg.station_mac;
         last_q <= frame_extra + rx_cfg.nbytes;
      end
      if (byte_done) begin
         wr_addr <= addr;
         wr_data <= byte_in;
         if (state == DEST) begin
            dest_sr <= {dest_sr[31:0], byte_in};
         end
      end
      if (status_load) begin
         status.crc_ok    <= (crc_value == `ETH_RX_CRC_RESIDUE);
         status.last_addr <= last_q;
      end
   end

   assign buf_wr    = '{en: wr_en, addr: wr_addr, data: wr_data};
   assign crc_start = (state == HUNT);

endmodule

// ==== src/eth_rx_crc.sv ====
`timescale 1ns/100ps

module eth_rx_crc
   import eth_rx_pkg::*;
(
   input  logic        RX_CLK,
   input  logic        rx_rst,
   input  logic        start,
   input  buf_wr_t     wr,
   output logic [31:0] crc_value
);

   localparam logic [31:0] poly = 32'h04C11DB7;

   logic [31:0] crc_q;

   // data bits enter lsb first, register shifts toward msb
   function automatic logic [31:0] crc_step(input logic [31:0] crc, input logic [7:0] data);
      logic [31:0] c;
      logic        fb;
      int          i;
      c = crc;
      for (i = 0; i < 8; i++) begin
         fb = c[31] ^ data[i];
         c  = {c[30:0], 1'b0};
         if (fb) begin
            c = c ^ poly;
         end
      end
      return c;
   endfunction

   always_ff @(posedge RX_CLK or posedge rx_rst) begin
      if (rx_rst) begin
         crc_q <= '1;
      end else if (start) begin
         crc_q <= '1;
      end else if (wr.en) begin
         crc_q <= crc_step(crc_q, wr.data);
      end
   end

   // no final inversion, a good frame leaves the residue
   assign crc_value = crc_q;

endmodule

// ==== src/eth_rx_cfg_regs.sv ====
`timescale 1ns/100ps
`include "eth_rx_defs.svh"

module eth_rx_cfg_regs
   import eth_rx_pkg::*;
(
   input  logic    RX_CLK,
   input  logic    rx_rst,
   input  logic    cfg_stb,
   input  cfg_wr_t cfg,
   output rx_cfg_t rx_cfg
);

   logic [47:0]               station_mac;
   logic [`ETH_RX_ADDR_W-1:0] nbytes;

   // one write per strobe, no back-pressure
   always_ff @(posedge RX_CLK or posedge rx_rst) begin
      if (rx_rst) begin
         station_mac <= `ETH_RX_MAC_RESET;
         nbytes      <= `ETH_RX_NBYTES_RESET;
      end else if (cfg_stb) begin
         case (cfg.op)
            SET_MAC_HI: begin
               station_mac[47:32] <= cfg.value[15:0];
            end
            SET_MAC_LO: begin
               station_mac[31:0] <= cfg.value;
            end
            SET_NBYTES: begin
               nbytes <= cfg.value[`ETH_RX_ADDR_W-1:0];
            end
            default: begin
               // unused opcode, ignored
            end
         endcase
      end
   end

   // receiver samples these at the SFD
   assign rx_cfg = '{station_mac: station_mac, nbytes: nbytes};

endmodule

// ==== src/eth_rx_pkg.sv ====
`include "eth_rx_defs.svh"

package eth_rx_pkg;

   typedef enum logic [2:0] {
      HUNT,
      DEST,
      BODY,
      DONE
   } rx_state_e;

   typedef enum logic [1:0] {
      SET_MAC_HI,
      SET_MAC_LO,
      SET_NBYTES
   } cfg_op_e;

   // MII receive side, one nibble per clock
   typedef struct packed {
      logic       dv;
      logic [3:0] nibble;
   } mii_rx_t;

   typedef struct packed {
      cfg_op_e     op;
      logic [31:0] value;
   } cfg_wr_t;

   typedef struct packed {
      logic [47:0]               station_mac;
      logic [`ETH_RX_ADDR_W-1:0] nbytes;
   } rx_cfg_t;

   typedef struct packed {
      logic                      en;
      logic [`ETH_RX_ADDR_W-1:0] addr;
      logic [7:0]                data;
   } buf_wr_t;

   typedef struct packed {
      logic                      crc_ok;
      logic [`ETH_RX_ADDR_W-1:0] last_addr;
   } rx_status_t;

endpackage

// ==== include/eth_rx_defs.svh ====
`ifndef ETH_RX_DEFS_SVH
`define ETH_RX_DEFS_SVH

// frame buffer geometry
`define ETH_RX_ADDR_W 11
`define ETH_RX_BUF_DEPTH 2048

// station address after reset, locally administered
`define ETH_RX_MAC_RESET 48'h02_00_00_A1_B2_C3

// payload length after reset, minimum Ethernet payload
`define ETH_RX_NBYTES_RESET 11'd46

// start-of-frame delimiter as it appears after nibble assembly
`define ETH_RX_SFD 8'hD5

// crc register after a frame with a good FCS
`define ETH_RX_CRC_RESIDUE 32'hC704DD7B

`endif
